// ==== all.f ====
design/cp0_pkg.sv
design/cp0_cmd_if.sv
design/cp0_op_sequencer.sv
design/cp0_regs.sv
design/tlb.sv
design/cp0_top.sv
dv/cp0_assert.sv
dv/cp0_tb.sv

// ==== design/cp0_cmd_if.sv ====
`timescale 1ns/1ps

interface cp0_cmd_if;
	import cp0_pkg::*;

	cp0_op_e   op;      // OP_NONE outside execute cycles.
	reg_addr_t addr;
	word_t     wdata;
	word_t     rdata;   // mfc0 result, combinational.
	logic      busy;    // exception taken, op is dropped this cycle.

	modport seq (
		output op,
		output addr,
		output wdata,
		input  rdata,
		input  busy
	);

	modport regs (
		input  op,
		input  addr,
		input  wdata,
		output rdata,
		output busy
	);

endinterface

// ==== design/cp0_op_sequencer.sv ====
`timescale 1ns/1ps

module cp0_op_sequencer #(
	parameter int TLB_ENTRIES = 8
) (
	input  logic                clk,
	input  logic                rst,

	input  logic                req_i,
	input  cp0_pkg::cp0_op_e    op_i,
	input  cp0_pkg::reg_addr_t  addr_i,
	input  cp0_pkg::word_t      wdata_i,
	output logic                ack_o,
	output cp0_pkg::word_t      rdata_o,

	cp0_cmd_if.seq              cmd
);
	import cp0_pkg::*;

	localparam int IDX_W = $clog2(TLB_ENTRIES);

	typedef enum logic [1:0] {
		IDLE,
		EXEC,
		ACK_WAIT
	} state_e;

	state_e    state_q;
	cp0_op_e   op_q;
	reg_addr_t addr_q;
	word_t     wdata_q;
	word_t     rdata_q;

	// the index field of the register file assumes a full binary range.
	if ((1 << IDX_W) != TLB_ENTRIES) begin : g_entries_check
		$error("TLB_ENTRIES must be a power of two");
	end

	// ------------------------------------------------------------------------
	// handshake state machine
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= IDLE;
			rdata_q <= '0;
		end else begin
			case (state_q)
				IDLE: begin
					if (req_i) begin
						state_q <= EXEC;        // command captured below.
					end
				end
				EXEC: begin
					if (!cmd.busy) begin
						rdata_q <= cmd.rdata;
						state_q <= ACK_WAIT;
					end                         // else retry next cycle.
				end
				ACK_WAIT: begin
					if (!req_i) begin
						state_q <= IDLE;
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// command latch, only loaded from idle.
	always_ff @(posedge clk) begin
		if (state_q == IDLE && req_i) begin
			op_q    <= op_i;
			addr_q  <= addr_i;
			wdata_q <= wdata_i;
		end
	end

	assign cmd.op    = (state_q == EXEC) ? op_q : OP_NONE;
	assign cmd.addr  = addr_q;
	assign cmd.wdata = wdata_q;

	assign ack_o   = (state_q == ACK_WAIT);
	assign rdata_o = rdata_q;

endmodule

// ==== design/cp0_pkg.sv ====
package cp0_pkg;

	// ------------------------------------------------------------------------
	// field types
	// ------------------------------------------------------------------------
	typedef logic [31:0] word_t;        // data word.
	typedef logic [18:0] vpn_t;         // entryhi bits 26..8.
	typedef logic [7:0]  asid_t;        // entryhi bits 7..0.
	typedef logic [19:0] pfn_t;         // entrylo bits 25..6.
	typedef logic [4:0]  reg_addr_t;    // coprocessor register number.
	typedef logic [4:0]  exc_code_t;    // cause.exccode.
	typedef logic [5:0]  hwirq_t;       // hardware interrupt lines.

	typedef enum logic [2:0] {
		OP_NONE  = 3'd0,
		OP_MFC0  = 3'd1,
		OP_MTC0  = 3'd2,
		OP_ERET  = 3'd3,
		OP_TLBR  = 3'd4,
		OP_TLBWI = 3'd5,
		OP_TLBP  = 3'd6
	} cp0_op_e;

	// ------------------------------------------------------------------------
	// register numbers
	// ------------------------------------------------------------------------
	localparam reg_addr_t REG_INDEX    = 5'd0;
	localparam reg_addr_t REG_ENTRYLO0 = 5'd2;
	localparam reg_addr_t REG_ENTRYLO1 = 5'd3;
	localparam reg_addr_t REG_ENTRYHI  = 5'd10;
	localparam reg_addr_t REG_STATUS   = 5'd12;
	localparam reg_addr_t REG_CAUSE    = 5'd13;
	localparam reg_addr_t REG_EPC      = 5'd14;
	localparam reg_addr_t REG_PRID     = 5'd15;

	// exception codes, all ones means nothing pending.
	localparam exc_code_t EXC_NONE = 5'b11111;
	localparam exc_code_t EXC_INT  = 5'd0;

	// bit positions inside status and cause.
	localparam int ST_IE    = 0;
	localparam int ST_EXL   = 1;
	localparam int CAUSE_BD = 31;

	localparam word_t CP0_PRID = 32'h0001_8003;   // company 01, impl 80, rev 03.

endpackage

// ==== design/cp0_regs.sv ====
`timescale 1ns/1ps

module cp0_regs #(
	parameter int TLB_ENTRIES = 8,
	localparam int IDX_W = $clog2(TLB_ENTRIES)
) (
	input  logic                clk,
	input  logic                rst,

	cp0_cmd_if.regs             cmd,

	input  cp0_pkg::exc_code_t  exc_i,
	input  cp0_pkg::hwirq_t     hwirq_i,
	input  logic                in_bds_i,
	input  cp0_pkg::word_t      curr_pc_i,
	output logic                take_o,
	output cp0_pkg::word_t      epc_o,

	output logic                tlb_we_o,
	output logic [IDX_W-1:0]    tlb_index_o,
	output cp0_pkg::word_t      entryhi_o,
	output cp0_pkg::word_t      entrylo0_o,
	output cp0_pkg::word_t      entrylo1_o,

	input  cp0_pkg::word_t      rd_entryhi_i,
	input  cp0_pkg::word_t      rd_entrylo0_i,
	input  cp0_pkg::word_t      rd_entrylo1_i,
	input  logic                probe_hit_i,
	input  logic [IDX_W-1:0]    probe_index_i
);
	import cp0_pkg::*;

	word_t index_q;
	word_t entrylo0_q;
	word_t entrylo1_q;
	word_t entryhi_q;
	word_t status_q;
	word_t cause_q;
	word_t epc_q;

	logic irq_take;
	logic exc_take;
	logic g_and;

	// keeps pfn, d, v and g.
	function automatic word_t mask_lo(input word_t w);
		return {6'b0, w[25:6], 3'b0, w[2:0]};
	endfunction

	// keeps vpn and asid.
	function automatic word_t mask_hi(input word_t w);
		return {5'b0, w[26:8], w[7:0]};
	endfunction

	// ------------------------------------------------------------------------
	// exception and interrupt decision
	// ------------------------------------------------------------------------
	assign irq_take = status_q[ST_IE] && !status_q[ST_EXL] &&
		((hwirq_i & status_q[15:10]) != '0);
	assign exc_take = (exc_i != EXC_NONE) && !status_q[ST_EXL];

	assign take_o   = irq_take || exc_take;
	assign cmd.busy = take_o;              // sequencer replays the op.

	// ------------------------------------------------------------------------
	// mfc0 read mux
	// ------------------------------------------------------------------------
	always_comb begin
		case (cmd.addr)
			REG_INDEX:    cmd.rdata = index_q;
			REG_ENTRYLO0: cmd.rdata = entrylo0_q;
			REG_ENTRYLO1: cmd.rdata = entrylo1_q;
			REG_ENTRYHI:  cmd.rdata = entryhi_q;
			REG_STATUS:   cmd.rdata = status_q;
			REG_CAUSE:    cmd.rdata = cause_q;
			REG_EPC:      cmd.rdata = epc_q;
			REG_PRID:     cmd.rdata = CP0_PRID;
			default:      cmd.rdata = '0;
		endcase
	end

	// global bit of a tlbr result.
	assign g_and = rd_entrylo0_i[0] & rd_entrylo1_i[0];

	always_ff @(posedge clk) begin
		if (rst) begin
			index_q    <= '0;
			entrylo0_q <= '0;
			entrylo1_q <= '0;
			entryhi_q  <= '0;
			status_q   <= '0;
			cause_q    <= '0;
			epc_q      <= '0;
		end else begin
			cause_q[15:10] <= hwirq_i;     // ip follows the lines.
			if (take_o) begin
				status_q[ST_EXL]  <= 1'b1;
				cause_q[CAUSE_BD] <= in_bds_i;
				cause_q[6:2]      <= irq_take ? EXC_INT : exc_i;
				// restart at the branch when the fault sits in its delay slot
				epc_q <= in_bds_i ? curr_pc_i - 32'd4 : curr_pc_i;
			end else begin
				case (cmd.op)
					OP_MTC0: begin
						case (cmd.addr)
							REG_INDEX: index_q <= {cmd.wdata[31],
								{(31 - IDX_W){1'b0}}, cmd.wdata[IDX_W-1:0]};
							REG_ENTRYLO0: entrylo0_q <= mask_lo(cmd.wdata);
							REG_ENTRYLO1: entrylo1_q <= mask_lo(cmd.wdata);
							REG_ENTRYHI:  entryhi_q  <= mask_hi(cmd.wdata);
							REG_STATUS: status_q <= {16'b0, cmd.wdata[15:10], 8'b0,
								cmd.wdata[1:0]};   // im, exl, ie.
							REG_EPC: epc_q <= cmd.wdata;
							default: ;                 // cause is read only.
						endcase
					end
					OP_ERET: status_q[ST_EXL] <= 1'b0;
					OP_TLBR: begin
						entryhi_q  <= mask_hi(rd_entryhi_i);
						entrylo0_q <= mask_lo({rd_entrylo0_i[31:1], g_and});
						entrylo1_q <= mask_lo({rd_entrylo1_i[31:1], g_and});
					end
					OP_TLBP: begin
						if (probe_hit_i) begin
							index_q[31]        <= 1'b0;
							index_q[IDX_W-1:0] <= probe_index_i;
						end else begin
							index_q[31] <= 1'b1;   // miss keeps the old index.
						end
					end
					default: ;
				endcase
			end
		end
	end

	assign epc_o = epc_q;

	assign tlb_we_o    = (cmd.op == OP_TLBWI) && !take_o;
	assign tlb_index_o = index_q[IDX_W-1:0];
	assign entryhi_o   = entryhi_q;
	assign entrylo0_o  = entrylo0_q;
	assign entrylo1_o  = entrylo1_q;

endmodule

// ==== design/cp0_top.sv ====
`timescale 1ns/1ps

module cp0_top #(
	parameter int TLB_ENTRIES = 8,
	localparam int IDX_W = $clog2(TLB_ENTRIES)
) (
	input  logic                clk,
	input  logic                rst,

	// command port, four-phase req/ack.
	input  logic                req_i,
	input  cp0_pkg::cp0_op_e    op_i,
	input  cp0_pkg::reg_addr_t  addr_i,
	input  cp0_pkg::word_t      wdata_i,
	output logic                ack_o,
	output cp0_pkg::word_t      rdata_o,

	// exception side.
	input  cp0_pkg::exc_code_t  exc_i,
	input  cp0_pkg::hwirq_t     hwirq_i,
	input  logic                in_bds_i,
	input  cp0_pkg::word_t      curr_pc_i,
	output logic                take_o,
	output cp0_pkg::word_t      epc_o
);
	import cp0_pkg::*;

	logic             tlb_we;
	logic [IDX_W-1:0] tlb_index;
	word_t            entryhi;
	word_t            entrylo0;
	word_t            entrylo1;
	word_t            rd_entryhi;
	word_t            rd_entrylo0;
	word_t            rd_entrylo1;
	logic             probe_hit;
	logic [IDX_W-1:0] probe_index;

	cp0_cmd_if cmd_if ();

	cp0_op_sequencer #(.TLB_ENTRIES(TLB_ENTRIES)) u_seq (
		.clk     (clk),
		.rst     (rst),
		.req_i   (req_i),
		.op_i    (op_i),
		.addr_i  (addr_i),
		.wdata_i (wdata_i),
		.ack_o   (ack_o),
		.rdata_o (rdata_o),
		.cmd     (cmd_if.seq)
	);

	cp0_regs #(.TLB_ENTRIES(TLB_ENTRIES)) u_regs (
		.clk           (clk),
		.rst           (rst),
		.cmd           (cmd_if.regs),
		.exc_i         (exc_i),
		.hwirq_i       (hwirq_i),
		.in_bds_i      (in_bds_i),
		.curr_pc_i     (curr_pc_i),
		.take_o        (take_o),
		.epc_o         (epc_o),
		.tlb_we_o      (tlb_we),
		.tlb_index_o   (tlb_index),
		.entryhi_o     (entryhi),
		.entrylo0_o    (entrylo0),
		.entrylo1_o    (entrylo1),
		.rd_entryhi_i  (rd_entryhi),
		.rd_entrylo0_i (rd_entrylo0),
		.rd_entrylo1_i (rd_entrylo1),
		.probe_hit_i   (probe_hit),
		.probe_index_i (probe_index)
	);

	tlb #(.TLB_ENTRIES(TLB_ENTRIES)) u_tlb (
		.clk           (clk),
		.rst           (rst),
		.we_i          (tlb_we),
		.index_i       (tlb_index),
		.entryhi_i     (entryhi),
		.entrylo0_i    (entrylo0),
		.entrylo1_i    (entrylo1),
		.rd_entryhi_o  (rd_entryhi),
		.rd_entrylo0_o (rd_entrylo0),
		.rd_entrylo1_o (rd_entrylo1),
		.probe_hit_o   (probe_hit),
		.probe_index_o (probe_index)
	);

endmodule

// ==== design/tlb.sv ====
`timescale 1ns/1ps

module tlb #(
	parameter int TLB_ENTRIES = 8,
	localparam int IDX_W = $clog2(TLB_ENTRIES)
) (
	input  logic                clk,
	input  logic                rst,

	input  logic                we_i,
	input  logic [IDX_W-1:0]    index_i,
	input  cp0_pkg::word_t      entryhi_i,
	input  cp0_pkg::word_t      entrylo0_i,
	input  cp0_pkg::word_t      entrylo1_i,

	output cp0_pkg::word_t      rd_entryhi_o,
	output cp0_pkg::word_t      rd_entrylo0_o,
	output cp0_pkg::word_t      rd_entrylo1_o,
	output logic                probe_hit_o,
	output logic [IDX_W-1:0]    probe_index_o
);
	import cp0_pkg::*;

	// ------------------------------------------------------------------------
	// entry storage
	// ------------------------------------------------------------------------
	vpn_t       vpn_q  [TLB_ENTRIES];
	asid_t      asid_q [TLB_ENTRIES];
	logic       g_q    [TLB_ENTRIES];    // and of both lo g bits.
	pfn_t       pfn0_q [TLB_ENTRIES];
	pfn_t       pfn1_q [TLB_ENTRIES];
	logic [1:0] dv0_q  [TLB_ENTRIES];    // {d, v}.
	logic [1:0] dv1_q  [TLB_ENTRIES];

	logic [TLB_ENTRIES-1:0] match;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < TLB_ENTRIES; i++) begin
				vpn_q[i]  <= '0;
				asid_q[i] <= '0;
				g_q[i]    <= 1'b0;
				pfn0_q[i] <= '0;
				pfn1_q[i] <= '0;
				dv0_q[i]  <= '0;
				dv1_q[i]  <= '0;
			end
		end else if (we_i) begin
			vpn_q[index_i]  <= entryhi_i[26:8];
			asid_q[index_i] <= entryhi_i[7:0];
			g_q[index_i]    <= entrylo0_i[0] & entrylo1_i[0];
			pfn0_q[index_i] <= entrylo0_i[25:6];
			pfn1_q[index_i] <= entrylo1_i[25:6];
			dv0_q[index_i]  <= entrylo0_i[2:1];
			dv1_q[index_i]  <= entrylo1_i[2:1];
		end
	end

	// indexed read, g is returned in both lo words.
	assign rd_entryhi_o  = {5'b0, vpn_q[index_i], asid_q[index_i]};
	assign rd_entrylo0_o = {6'b0, pfn0_q[index_i], 3'b0, dv0_q[index_i], g_q[index_i]};
	assign rd_entrylo1_o = {6'b0, pfn1_q[index_i], 3'b0, dv1_q[index_i], g_q[index_i]};

	// ------------------------------------------------------------------------
	// parallel probe against entryhi
	// ------------------------------------------------------------------------
	always_comb begin
		for (int i = 0; i < TLB_ENTRIES; i++) begin
			match[i] = (vpn_q[i] == entryhi_i[26:8]) &&
				(g_q[i] || (asid_q[i] == entryhi_i[7:0]));
		end
	end

	// scan downward so the lowest match is the last one assigned
	always_comb begin
		probe_hit_o   = 1'b0;
		probe_index_o = '0;
		for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
			if (match[i]) begin
				probe_hit_o   = 1'b1;
				probe_index_o = IDX_W'(i);
			end
		end
	end

endmodule

// ==== dv/cp0_assert.sv ====
`timescale 1ns/1ps

module cp0_assert (
	input  logic            clk,
	input  logic            rst,
	input  logic            req_i,
	input  logic            ack_i,
	input  cp0_pkg::word_t  rdata_i,
	input  logic            take_i,
	input  logic            exl_i
);
	int fail_cnt = 0;      // failed assertions so far.

	// ------------------------------------------------------------------------
	// four-phase command handshake
	// ------------------------------------------------------------------------
	a_ack_rise: assert property (@(posedge clk) disable iff (rst)
		$rose(ack_i) |-> $past(req_i))
		else begin
			fail_cnt++;
			$error("ack rose without a pending request");
		end

	a_ack_fall: assert property (@(posedge clk) disable iff (rst)
		$fell(ack_i) |-> $past(!req_i))
		else begin
			fail_cnt++;
			$error("ack fell while the request was still high");
		end

	a_rdata_hold: assert property (@(posedge clk) disable iff (rst)
		ack_i && $past(ack_i) |-> $stable(rdata_i))
		else begin
			fail_cnt++;
			$error("read data changed while ack was high");
		end

	// an entry sets EXL and so blocks a nested entry in the next cycle.
	a_take_exl: assert property (@(posedge clk) disable iff (rst)
		take_i |=> exl_i && !take_i)
		else begin
			fail_cnt++;
			$error("exception entry left EXL clear or was taken again");
		end

endmodule

bind cp0_top cp0_assert u_chk (
	.clk     (clk),
	.rst     (rst),
	.req_i   (req_i),
	.ack_i   (ack_o),
	.rdata_i (rdata_o),
	.take_i  (take_o),
	.exl_i   (u_regs.status_q[cp0_pkg::ST_EXL])
);

// ==== dv/cp0_tb.sv ====
`timescale 1ns/1ps

module cp0_tb;
	import cp0_pkg::*;

	localparam int    TLB_ENTRIES = 8;
	localparam int    TIMEOUT     = 20;                 // cycles per handshake phase.
	localparam word_t IDX_MASK    = 32'h8000_0000 | word_t'(TLB_ENTRIES - 1);
	localparam word_t LO_MASK     = 32'h03ff_ffc7;      // pfn, d, v, g.
	localparam word_t HI_MASK     = 32'h07ff_ffff;      // vpn, asid.
	localparam word_t ST_MASK     = 32'h0000_fc03;      // im, exl, ie.

	logic      clk;
	logic      rst;
	logic      req_i;
	cp0_op_e   op_i;
	reg_addr_t addr_i;
	word_t     wdata_i;
	logic      ack_o;
	word_t     rdata_o;
	exc_code_t exc_i;
	hwirq_t    hwirq_i;
	logic      in_bds_i;
	word_t     curr_pc_i;
	logic      take_o;
	word_t     epc_o;

	int        errors;
	int        timeouts;
	int        take_cnt;
	int        takes_before;
	integer    seed;
	reg_addr_t rw_addr [6];
	word_t     rw_mask [6];
	int        idx_l [3];
	word_t     hi_w [3];
	word_t     lo0_w [3];
	word_t     lo1_w [3];
	word_t     w;
	word_t     pc;
	word_t     got;
	logic      g;

	cp0_top #(.TLB_ENTRIES(TLB_ENTRIES)) DUT (
		.clk       (clk),
		.rst       (rst),
		.req_i     (req_i),
		.op_i      (op_i),
		.addr_i    (addr_i),
		.wdata_i   (wdata_i),
		.ack_o     (ack_o),
		.rdata_o   (rdata_o),
		.exc_i     (exc_i),
		.hwirq_i   (hwirq_i),
		.in_bds_i  (in_bds_i),
		.curr_pc_i (curr_pc_i),
		.take_o    (take_o),
		.epc_o     (epc_o)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// one count per cycle with an exception or interrupt entry.
	always @(negedge clk) begin
		if (take_o) take_cnt++;
	end

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------
	task automatic check_word(input word_t got_w, input word_t exp_w, input string what);
		assert (got_w === exp_w) else begin
			errors++;
			$display("** Error at %0t ns: %s got %h, expected %h", $time, what, got_w, exp_w);
		end
	endtask

	// one four-phase transaction, hold keeps req high after ack.
	task automatic do_cmd(input cp0_op_e op, input reg_addr_t addr, input word_t wdata,
		input int hold, output word_t rdata);
		int n;
		op_i    = op;
		addr_i  = addr;
		wdata_i = wdata;
		req_i   = 1'b1;
		n       = 0;
		do begin
			@(posedge clk);
			#5;
			n++;
		end while (!ack_o && n < TIMEOUT);
		if (!ack_o) begin
			timeouts++;
			$display("Timeout at %0t ns: %s got no acknowledge", $time, op.name());
		end
		rdata = rdata_o;
		repeat (hold) begin
			@(posedge clk);
			#5;
			check_word(rdata_o, rdata, "rdata_o under back-pressure");
		end
		req_i = 1'b0;
		n     = 0;
		do begin
			@(posedge clk);
			#5;
			n++;
		end while (ack_o && n < TIMEOUT);
		if (ack_o) begin
			timeouts++;
			$display("Timeout at %0t ns: ack stayed high after the request dropped", $time);
		end
	endtask

	task automatic write_reg(input reg_addr_t addr, input word_t data);
		word_t unused;
		do_cmd(OP_MTC0, addr, data, 0, unused);
	endtask

	task automatic expect_reg(input reg_addr_t addr, input word_t exp_w, input string what);
		word_t rd;
		do_cmd(OP_MFC0, addr, '0, 0, rd);
		check_word(rd, exp_w, what);
	endtask

	task automatic run_op(input cp0_op_e op);
		word_t unused;
		do_cmd(op, '0, '0, 0, unused);
	endtask

	// exception request held for exactly one cycle.
	task automatic raise_exc(input exc_code_t code, input logic bds, input word_t at_pc);
		exc_i     = code;
		in_bds_i  = bds;
		curr_pc_i = at_pc;
		@(posedge clk);
		#5;
		exc_i    = EXC_NONE;
		in_bds_i = 1'b0;
	endtask

	// ------------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------------
	initial begin
		seed      = 32'h8971;
		errors    = 0;
		timeouts  = 0;
		take_cnt  = 0;
		rst       = 1'b1;
		req_i     = 1'b0;
		op_i      = OP_NONE;
		addr_i    = '0;
		wdata_i   = '0;
		exc_i     = EXC_NONE;
		hwirq_i   = '0;
		in_bds_i  = 1'b0;
		curr_pc_i = '0;
		rw_addr   = '{REG_INDEX, REG_ENTRYLO0, REG_ENTRYLO1, REG_ENTRYHI, REG_STATUS, REG_EPC};
		rw_mask   = '{IDX_MASK, LO_MASK, LO_MASK, HI_MASK, ST_MASK, 32'hffff_ffff};
		idx_l     = '{1, 3, 6};
		repeat (4) @(posedge clk);
		#5;
		rst = 1'b0;

		// register moves.
		foreach (rw_addr[k]) begin
			w = $random(seed);
			write_reg(rw_addr[k], w);
			expect_reg(rw_addr[k], w & rw_mask[k], $sformatf("register %0d", rw_addr[k]));
		end
		write_reg(REG_CAUSE, $random(seed));
		expect_reg(REG_CAUSE, '0, "Cause after MTC0");
		expect_reg(REG_PRID, CP0_PRID, "PRId");
		expect_reg(5'd7, '0, "unlisted register");
		write_reg(REG_STATUS, '0);

		// tlb write then read back.
		foreach (idx_l[k]) begin
			hi_w[k]  = $random(seed);
			lo0_w[k] = $random(seed);
			lo1_w[k] = $random(seed);
			if (k == 0) begin
				lo0_w[k][0] = 1'b1;         // g bits differ.
				lo1_w[k][0] = 1'b0;
			end
			if (k == 2) begin
				lo0_w[k][0] = 1'b1;         // global entry.
				lo1_w[k][0] = 1'b1;
			end
			write_reg(REG_INDEX, word_t'(idx_l[k]));
			write_reg(REG_ENTRYHI, hi_w[k]);
			write_reg(REG_ENTRYLO0, lo0_w[k]);
			write_reg(REG_ENTRYLO1, lo1_w[k]);
			run_op(OP_TLBWI);
		end
		write_reg(REG_ENTRYHI, '0);
		write_reg(REG_ENTRYLO0, '0);
		write_reg(REG_ENTRYLO1, '0);
		foreach (idx_l[k]) begin
			write_reg(REG_INDEX, word_t'(idx_l[k]));
			run_op(OP_TLBR);
			g = lo0_w[k][0] & lo1_w[k][0];
			expect_reg(REG_ENTRYHI, hi_w[k] & HI_MASK, "EntryHi after TLBR");
			expect_reg(REG_ENTRYLO0, (lo0_w[k] & LO_MASK & ~32'h1) | {31'b0, g},
				"EntryLo0 after TLBR");
			expect_reg(REG_ENTRYLO1, (lo1_w[k] & LO_MASK & ~32'h1) | {31'b0, g},
				"EntryLo1 after TLBR");
		end

		// probes: asid hit, global hit under another asid, then a miss.
		write_reg(REG_INDEX, '0);
		write_reg(REG_ENTRYHI, hi_w[0]);
		run_op(OP_TLBP);
		expect_reg(REG_INDEX, word_t'(idx_l[0]), "Index after TLBP hit");
		write_reg(REG_ENTRYHI, hi_w[2] ^ 32'h0000_00ff);
		run_op(OP_TLBP);
		expect_reg(REG_INDEX, word_t'(idx_l[2]), "Index after global TLBP hit");
		write_reg(REG_ENTRYHI, hi_w[1] ^ 32'h0000_0100);
		run_op(OP_TLBP);
		expect_reg(REG_INDEX, 32'h8000_0000 | word_t'(idx_l[2]), "Index after TLBP miss");

		// exception entry outside and inside a delay slot.
		pc           = $random(seed) & ~32'h3;
		takes_before = take_cnt;
		raise_exc(5'd4, 1'b0, pc);
		check_word(take_cnt - takes_before, 1, "exception entries");
		expect_reg(REG_EPC, pc, "EPC after exception");
		expect_reg(REG_CAUSE, {1'b0, 15'b0, 6'b0, 3'b0, 5'd4, 2'b0}, "Cause after exception");
		expect_reg(REG_STATUS, 32'h0000_0002, "Status with EXL set");
		takes_before = take_cnt;
		raise_exc(5'd5, 1'b0, pc + 32'h40);
		check_word(take_cnt - takes_before, 0, "exception entries with EXL set");
		expect_reg(REG_EPC, pc, "EPC kept while EXL set");
		run_op(OP_ERET);
		expect_reg(REG_STATUS, '0, "Status after ERET");
		pc           = $random(seed) & ~32'h3;
		takes_before = take_cnt;
		raise_exc(5'd10, 1'b1, pc);
		check_word(take_cnt - takes_before, 1, "delay slot exception entries");
		expect_reg(REG_EPC, pc - 32'd4, "EPC for a delay slot");
		expect_reg(REG_CAUSE, {1'b1, 15'b0, 6'b0, 3'b0, 5'd10, 2'b0}, "Cause with BD");
		run_op(OP_ERET);

		// interrupt line 2 maps to im bit 12.
		write_reg(REG_STATUS, 32'h0000_0001);
		takes_before = take_cnt;
		hwirq_i      = 6'b000100;
		expect_reg(REG_CAUSE, {1'b1, 15'b0, 6'b000100, 3'b0, 5'd10, 2'b0}, "Cause IP");
		write_reg(REG_STATUS, 32'h0000_1000);
		check_word(take_cnt - takes_before, 0, "masked interrupt entries");
		pc        = $random(seed) & ~32'h3;
		curr_pc_i = pc;
		write_reg(REG_STATUS, 32'h0000_1001);
		check_word(take_cnt - takes_before, 1, "enabled interrupt entries");
		expect_reg(REG_CAUSE, {1'b0, 15'b0, 6'b000100, 3'b0, EXC_INT, 2'b0},
			"Cause after interrupt");
		expect_reg(REG_EPC, pc, "EPC after interrupt");
		hwirq_i = '0;
		run_op(OP_ERET);
		write_reg(REG_STATUS, '0);

		// back-pressure, then an exception colliding with MTC0 to EPC.
		do_cmd(OP_MFC0, REG_PRID, '0, 4, got);
		check_word(got, CP0_PRID, "PRId under back-pressure");
		pc           = $random(seed) & ~32'h3;
		w            = $random(seed);
		takes_before = take_cnt;
		fork
			do_cmd(OP_MTC0, REG_EPC, w, 0, got);
			begin
				@(posedge clk);
				#5;
				curr_pc_i = pc;
				exc_i     = 5'd12;           // lands in the execute cycle.
				@(posedge clk);
				#5;
				exc_i = EXC_NONE;
				check_word(epc_o, pc, "EPC saved by the colliding exception");
			end
		join
		check_word(take_cnt - takes_before, 1, "colliding exception entries");
		expect_reg(REG_EPC, w, "EPC after the retried MTC0");
		run_op(OP_ERET);

		repeat (2) @(posedge clk);
		$display("errors: %0d  timeouts: %0d  assertion failures: %0d",
			errors, timeouts, DUT.u_chk.fail_cnt);
		if (errors == 0 && timeouts == 0 && DUT.u_chk.fail_cnt == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule
